//--- hw/tlp_bridge_pkg.sv
// ---------------------------------------
// TLP bridge shared types and constants
// ---------------------------------------

package tlp_bridge_pkg;

    // ---------------------------------------
    // widths
    // ---------------------------------------

    // 64-bit core side
    localparam int CORE_DATA_W = 64;
    localparam int CORE_KEEP_W = 8;

    // 128-bit TLP side, four DWs per beat
    localparam int WIDE_DATA_W = 128;
    localparam int WIDE_DWS    = 4;

    localparam int BAR_HIT_W   = 7;

    // ---------------------------------------
    // core keep encodings
    // ---------------------------------------

    // both DWs of a core beat valid
    localparam logic [CORE_KEEP_W-1:0] KEEP_TWO_DW = 8'hff;
    // low DW only
    localparam logic [CORE_KEEP_W-1:0] KEEP_ONE_DW = 8'h0f;

    // ---------------------------------------
    // interrupt timer
    // ---------------------------------------

    // 60 s at 62.5 MHz user clock
    localparam logic [31:0] IRQ_PERIOD_CYCLES = 32'd3_750_000_000;

    // ---------------------------------------
    // beat types
    // ---------------------------------------

    // receive beat from the endpoint core
    typedef struct packed {
        logic [CORE_DATA_W-1:0] data;
        logic [CORE_KEEP_W-1:0] keep;
        logic                   last;
        logic [BAR_HIT_W-1:0]   bar_hit;
    } core_rx_beat_t;

    // transmit beat towards the endpoint core
    typedef struct packed {
        logic [CORE_DATA_W-1:0] data;
        logic [CORE_KEEP_W-1:0] keep;
        logic                   last;
    } core_tx_beat_t;

    // fabric-side TLP beat, DW0 sits in data[31:0]
    // keepdw is contiguous from bit 0
    typedef struct packed {
        logic [WIDE_DATA_W-1:0] data;
        logic [WIDE_DWS-1:0]    keepdw;
        logic                   first;
        logic                   last;
        logic [BAR_HIT_W-1:0]   bar_hit;
    } wide_beat_t;

endpackage

//--- hw/tlp_rx_widen.sv
// ---------------------------------------
// TLP receive widening 64 to 128
// ---------------------------------------

`timescale 1ns/1ps

module tlp_rx_widen (
    input  logic                          clk_pcie,
    input  logic                          rst,

    // core receive side, no back-pressure
    input  tlp_bridge_pkg::core_rx_beat_t core_rx,
    input  logic                          core_rx_valid,

    // wide TLP beats out
    output tlp_bridge_pkg::wide_beat_t    rx_out,
    output logic                          rx_out_valid
);

    import tlp_bridge_pkg::*;

    // ---------------------------------------
    // assembly state
    // ---------------------------------------

    logic [WIDE_DATA_W-1:0] asm_data;
    logic [BAR_HIT_W-1:0]   asm_bar_hit;

    // DWs collected so far, at most four
    logic [2:0]             dw_cnt;
    logic                   first_q;
    logic                   last_q;

    logic                   emit;
    logic [2:0]             next_base;
    logic [2:0]             next_cnt;

    // a wide beat leaves once it holds three or more DWs,
    // or once the TLP's final core beat has been absorbed
    assign emit = last_q || (dw_cnt > 3'd2);

    // an incoming beat restarts at DW0 when the current one leaves
    assign next_base = emit ? 3'd0 : dw_cnt;
    assign next_cnt  = next_base + 3'd1 + {2'b00, core_rx.keep[4]};

    // ---------------------------------------
    // control
    // ---------------------------------------

    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            dw_cnt  <= 3'd0;
            first_q <= 1'b1;
            last_q  <= 1'b0;
        end else begin
            // the beat after a last opens a new TLP
            if (emit) begin
                first_q <= last_q;
            end
            if (core_rx_valid) begin
                dw_cnt <= next_cnt;
                last_q <= core_rx.last;
            end else if (emit) begin
                dw_cnt <= 3'd0;
                last_q <= 1'b0;
            end
        end
    end

    // ---------------------------------------
    // payload
    // ---------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (core_rx_valid) begin
            asm_data[32*next_base +: CORE_DATA_W] <= core_rx.data;
            // bar hit follows the latest core beat
            asm_bar_hit <= core_rx.bar_hit;
        end
    end

    // ---------------------------------------
    // output beat
    // ---------------------------------------

    always_comb begin
        rx_out.data    = asm_data;
        rx_out.keepdw  = {dw_cnt > 3'd3, dw_cnt > 3'd2, dw_cnt > 3'd1, 1'b1};
        rx_out.first   = first_q;
        rx_out.last    = last_q;
        rx_out.bar_hit = asm_bar_hit;
    end

    assign rx_out_valid = emit;

endmodule

//--- hw/tlp_tx_narrow.sv
// ---------------------------------------
// TLP transmit narrowing 128 to 64
// ---------------------------------------

`timescale 1ns/1ps

module tlp_tx_narrow (
    input  logic                          clk_pcie,
    input  logic                          rst,

    // wide TLP beats in
    input  tlp_bridge_pkg::wide_beat_t    tx_in,
    input  logic                          tx_in_valid,
    output logic                          tx_in_ready,

    // core transmit side
    output tlp_bridge_pkg::core_tx_beat_t core_tx,
    output logic                          core_tx_valid,
    input  logic                          core_tx_ready
);

    import tlp_bridge_pkg::*;

    // pending upper half of a split beat
    logic [CORE_DATA_W-1:0] hi_data;
    logic                   hi_last;
    logic                   hi_keep_two;
    logic                   hi_valid;

    logic                   split;
    logic                   lo_keep_two;
    logic                   hi_load;

    // DW2 present means the beat needs two core beats
    assign split       = tx_in.keepdw[2];
    assign lo_keep_two = split || tx_in.keepdw[1];

    // upper half is captured only when the core takes the lower half
    assign hi_load = tx_in_valid && !hi_valid && split && core_tx_ready;

    // ---------------------------------------
    // core beat mux
    // ---------------------------------------

    always_comb begin
        if (hi_valid) begin
            core_tx.data = hi_data;
            core_tx.keep = hi_keep_two ? KEEP_TWO_DW : KEEP_ONE_DW;
            core_tx.last = hi_last;
        end else begin
            core_tx.data = tx_in.data[CORE_DATA_W-1:0];
            core_tx.keep = lo_keep_two ? KEEP_TWO_DW : KEEP_ONE_DW;
            core_tx.last = tx_in.last && !split;
        end
    end

    assign core_tx_valid = hi_valid || tx_in_valid;

    // wide beat retires with its final core beat
    assign tx_in_ready = core_tx_ready && (hi_valid || (tx_in_valid && !split));

    // ---------------------------------------
    // upper half register
    // ---------------------------------------

    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            hi_valid <= 1'b0;
        end else if (hi_valid && core_tx_ready) begin
            hi_valid <= 1'b0;
        end else if (hi_load) begin
            hi_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (hi_load) begin
            hi_data     <= tx_in.data[WIDE_DATA_W-1:CORE_DATA_W];
            hi_last     <= tx_in.last;
            hi_keep_two <= tx_in.keepdw[3];
        end
    end

endmodule

//--- hw/irq_period_timer.sv
// ---------------------------------------
// Periodic legacy interrupt
// ---------------------------------------

`timescale 1ns/1ps

module irq_period_timer #(
    parameter logic [31:0] IRQ_PERIOD = tlp_bridge_pkg::IRQ_PERIOD_CYCLES
) (
    input  logic clk_pcie,
    input  logic rst,

    // core interrupt handshake
    input  logic cfg_interrupt_rdy,
    output logic cfg_interrupt_assert
);

    logic [31:0] count;
    logic        expired;
    logic        wrap;

    assign wrap = (count == IRQ_PERIOD - 32'd1);

    // ---------------------------------------
    // period counter
    // ---------------------------------------

    // one-cycle expiry pulse registered at the wrap
    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            count   <= 32'd0;
            expired <= 1'b0;
        end else if (wrap) begin
            count   <= 32'd0;
            expired <= 1'b1;
        end else begin
            count   <= count + 32'd1;
            expired <= 1'b0;
        end
    end

    // ---------------------------------------
    // interrupt level
    // ---------------------------------------

    // set on expiry, held until the core is ready
    // a new expiry beats a clear in the same cycle
    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            cfg_interrupt_assert <= 1'b0;
        end else if (expired) begin
            cfg_interrupt_assert <= 1'b1;
        end else if (cfg_interrupt_rdy) begin
            cfg_interrupt_assert <= 1'b0;
        end
    end

endmodule

//--- hw/tlp_stream_bridge.sv
// ---------------------------------------
// PCIe TLP stream bridge
// ---------------------------------------

`timescale 1ns/1ps

module tlp_stream_bridge #(
    parameter logic [31:0] IRQ_PERIOD = tlp_bridge_pkg::IRQ_PERIOD_CYCLES
) (
    input  logic                          clk_pcie,
    input  logic                          rst,

    // core receive beats, 64 bit
    input  tlp_bridge_pkg::core_rx_beat_t core_rx,
    input  logic                          core_rx_valid,

    // fabric receive TLPs, 128 bit
    output tlp_bridge_pkg::wide_beat_t    rx_out,
    output logic                          rx_out_valid,

    // fabric transmit TLPs, 128 bit
    input  tlp_bridge_pkg::wide_beat_t    tx_in,
    input  logic                          tx_in_valid,
    output logic                          tx_in_ready,

    // core transmit beats, 64 bit
    output tlp_bridge_pkg::core_tx_beat_t core_tx,
    output logic                          core_tx_valid,
    input  logic                          core_tx_ready,

    // legacy interrupt
    input  logic                          cfg_interrupt_rdy,
    output logic                          cfg_interrupt_assert
);

    // ---------------------------------------
    // receive path
    // ---------------------------------------

    tlp_rx_widen i_tlp_rx_widen (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .core_rx       (core_rx),
        .core_rx_valid (core_rx_valid),
        .rx_out        (rx_out),
        .rx_out_valid  (rx_out_valid)
    );

    // ---------------------------------------
    // transmit path
    // ---------------------------------------

    tlp_tx_narrow i_tlp_tx_narrow (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .tx_in         (tx_in),
        .tx_in_valid   (tx_in_valid),
        .tx_in_ready   (tx_in_ready),
        .core_tx       (core_tx),
        .core_tx_valid (core_tx_valid),
        .core_tx_ready (core_tx_ready)
    );

    // ---------------------------------------
    // periodic interrupt
    // ---------------------------------------

    irq_period_timer #(
        .IRQ_PERIOD (IRQ_PERIOD)
    ) i_irq_period_timer (
        .clk_pcie             (clk_pcie),
        .rst                  (rst),
        .cfg_interrupt_rdy    (cfg_interrupt_rdy),
        .cfg_interrupt_assert (cfg_interrupt_assert)
    );

endmodule

//--- tests/tb_tlp_stream_bridge.sv
// ---------------------------------------
// TLP stream bridge testbench
// ---------------------------------------

`timescale 1ns/1ps

module tb_tlp_stream_bridge;

    import tlp_bridge_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 10;
    localparam int WATCHDOG_CYCLES = 2000;

    logic          clk_pcie;
    logic          rst;
    core_rx_beat_t core_rx;
    logic          core_rx_valid;
    wide_beat_t    rx_out;
    logic          rx_out_valid;
    wide_beat_t    tx_in;
    logic          tx_in_valid;
    logic          tx_in_ready;
    core_tx_beat_t core_tx;
    logic          core_tx_valid;
    logic          core_tx_ready;
    logic          cfg_interrupt_rdy;
    logic          cfg_interrupt_assert;

    int            mismatch_count = 0;
    int            protocol_count = 0;
    logic [31:0]   lfsr_state = 32'h3b98_3c82;

    // receive reference model state
    logic [31:0]   m_dw [0:3];
    int            m_cnt = 0;
    logic          m_first = 1'b1;
    wide_beat_t    exp_wide = '0;
    logic          exp_rx_valid = 1'b0;

    // core beats still expected on the transmit side
    core_tx_beat_t exp_tx_q [$];

    tlp_stream_bridge #(
        .IRQ_PERIOD (32'd16)
    ) i_dut (
        .clk_pcie             (clk_pcie),
        .rst                  (rst),
        .core_rx              (core_rx),
        .core_rx_valid        (core_rx_valid),
        .rx_out               (rx_out),
        .rx_out_valid         (rx_out_valid),
        .tx_in                (tx_in),
        .tx_in_valid          (tx_in_valid),
        .tx_in_ready          (tx_in_ready),
        .core_tx              (core_tx),
        .core_tx_valid        (core_tx_valid),
        .core_tx_ready        (core_tx_ready),
        .cfg_interrupt_rdy    (cfg_interrupt_rdy),
        .cfg_interrupt_assert (cfg_interrupt_assert)
    );

    initial begin
        clk_pcie = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pcie = ~clk_pcie;
    end

    // ---------------------------------------
    // helpers
    // ---------------------------------------

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[62:0], fb};
        end
        return r;
    endfunction

    task automatic check_bit(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            mismatch_count++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    // DWs outside keepdw carry no meaning and are masked off
    task automatic check_wide(input wide_beat_t act, input wide_beat_t exp, input string what);
        wide_beat_t a;
        wide_beat_t e;
        a = act;
        e = exp;
        for (int i = 0; i < WIDE_DWS; i++) begin
            if (!exp.keepdw[i]) begin
                a.data[32*i +: 32] = '0;
                e.data[32*i +: 32] = '0;
            end
        end
        if (a !== e) begin
            mismatch_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, a, e);
        end
    endtask

    task automatic check_core_tx(input core_tx_beat_t act, input core_tx_beat_t exp,
                                 input string what);
        if (act !== exp) begin
            mismatch_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    // packing rule applied to one absorbed core beat
    task automatic absorb_rx(input core_rx_beat_t beat, input int ndw);
        for (int i = 0; i < ndw; i++) begin
            m_dw[m_cnt + i] = beat.data[32*i +: 32];
        end
        m_cnt += ndw;
        exp_rx_valid = (m_cnt >= 3) || beat.last;
        if (exp_rx_valid) begin
            exp_wide.data    = {m_dw[3], m_dw[2], m_dw[1], m_dw[0]};
            for (int i = 0; i < WIDE_DWS; i++) begin
                exp_wide.keepdw[i] = (i < m_cnt);
            end
            exp_wide.first   = m_first;
            exp_wide.last    = beat.last;
            exp_wide.bar_hit = beat.bar_hit;
            m_first = beat.last;
            m_cnt   = 0;
        end
    endtask

    // one receive cycle
    // an ndw of zero leaves the bus idle
    task automatic rx_step(input int ndw, input logic last_beat);
        core_rx_beat_t beat;
        @(posedge clk_pcie);
        #DRIVE_DELAY;
        check_bit(rx_out_valid, exp_rx_valid, "rx_out_valid");
        if (exp_rx_valid && rx_out_valid) begin
            check_wide(rx_out, exp_wide, "rx_out");
        end
        if (ndw == 0) begin
            core_rx_valid = 1'b0;
            exp_rx_valid  = 1'b0;
        end else begin
            beat.data    = rand_bits(64);
            beat.keep    = (ndw == 2) ? KEEP_TWO_DW : KEEP_ONE_DW;
            beat.last    = last_beat;
            beat.bar_hit = BAR_HIT_W'(rand_bits(BAR_HIT_W));
            core_rx       = beat;
            core_rx_valid = 1'b1;
            absorb_rx(beat, ndw);
        end
    endtask

    // queues the core beats that the splitting rule gives for one wide beat
    task automatic push_split(input wide_beat_t beat);
        core_tx_beat_t c;
        c.data = beat.data[63:0];
        if (!beat.keepdw[2]) begin
            c.keep = beat.keepdw[1] ? KEEP_TWO_DW : KEEP_ONE_DW;
            c.last = beat.last;
            exp_tx_q.push_back(c);
        end else begin
            c.keep = KEEP_TWO_DW;
            c.last = 1'b0;
            exp_tx_q.push_back(c);
            c.data = beat.data[127:64];
            c.keep = beat.keepdw[3] ? KEEP_TWO_DW : KEEP_ONE_DW;
            c.last = beat.last;
            exp_tx_q.push_back(c);
        end
    endtask

    // holds one wide beat until it is taken
    task automatic drive_tx(input wide_beat_t beat, input logic random_ready);
        logic done;
        push_split(beat);
        done = 1'b0;
        @(posedge clk_pcie);
        #DRIVE_DELAY;
        tx_in       = beat;
        tx_in_valid = 1'b1;
        while (!done) begin
            core_tx_ready = random_ready ? 1'(rand_bits(1)) : 1'b1;
            @(negedge clk_pcie);
            done = tx_in_ready;
            if (!done) begin
                @(posedge clk_pcie);
                #DRIVE_DELAY;
            end
        end
    endtask

    task automatic finish_tx();
        @(posedge clk_pcie);
        #DRIVE_DELAY;
        tx_in_valid = 1'b0;
        @(posedge clk_pcie);
        if (exp_tx_q.size() != 0) begin
            protocol_count++;
            $display("%0d core transmit beats never appeared (time %0t ns)",
                     exp_tx_q.size(), $time);
            exp_tx_q.delete();
        end
    endtask

    // transmit monitor sampling in mid cycle
    always @(negedge clk_pcie) begin
        if (!rst) begin
            if (tx_in_ready && !core_tx_ready) begin
                protocol_count++;
                $display("tx_in_ready was high while core_tx_ready was low at %0t ns", $time);
            end
            if (core_tx_valid && core_tx_ready) begin
                if (exp_tx_q.size() == 0) begin
                    protocol_count++;
                    $display("the DUT sent a core transmit beat nobody expected at %0t ns",
                             $time);
                end else begin
                    check_core_tx(core_tx, exp_tx_q.pop_front(), "core_tx");
                end
            end
        end
    end

    // ---------------------------------------
    // directed tests
    // ---------------------------------------

    task automatic check_reset_state();
        check_bit(rx_out_valid, 1'b0, "rx_out_valid after reset");
        check_bit(cfg_interrupt_assert, 1'b0, "cfg_interrupt_assert after reset");
        check_bit(core_tx_valid, 1'b0, "core_tx_valid after reset");
    endtask

    // with a period of 16 the expiry comes at edge 16 and the level at edge 17
    task automatic test_interrupt();
        for (int e = 1; e <= 16; e++) begin
            @(posedge clk_pcie);
            #DRIVE_DELAY;
            check_bit(cfg_interrupt_assert, 1'b0, "cfg_interrupt_assert before expiry");
        end
        repeat (4) begin
            @(posedge clk_pcie);
            #DRIVE_DELAY;
            check_bit(cfg_interrupt_assert, 1'b1, "cfg_interrupt_assert held");
        end
        cfg_interrupt_rdy = 1'b1;
        @(posedge clk_pcie);
        #DRIVE_DELAY;
        check_bit(cfg_interrupt_assert, 1'b0, "cfg_interrupt_assert after rdy");
        cfg_interrupt_rdy = 1'b0;
        repeat (11) begin
            @(posedge clk_pcie);
            #DRIVE_DELAY;
            check_bit(cfg_interrupt_assert, 1'b0, "cfg_interrupt_assert between expiries");
        end
        @(posedge clk_pcie);
        #DRIVE_DELAY;
        check_bit(cfg_interrupt_assert, 1'b1, "cfg_interrupt_assert second rise");
        cfg_interrupt_rdy = 1'b1;
        @(posedge clk_pcie);
        #DRIVE_DELAY;
        check_bit(cfg_interrupt_assert, 1'b0, "cfg_interrupt_assert second clear");
    endtask

    // 5 DWs as 2 + 2 + 1
    task automatic test_rx_packing();
        rx_step(2, 1'b0);
        rx_step(2, 1'b0);
        rx_step(1, 1'b1);
        rx_step(0, 1'b0);
        rx_step(0, 1'b0);
    endtask

    task automatic test_rx_tlps();
        int len;
        repeat (24) begin
            len = int'(rand_bits(3)) % 6 + 1;
            while (len > 2) begin
                rx_step(2, 1'b0);
                len -= 2;
            end
            rx_step(len, 1'b1);
        end
        rx_step(0, 1'b0);
        rx_step(0, 1'b0);
    endtask

    task automatic test_tx_split();
        wide_beat_t b;
        b = '0;
        b.last = 1'b1;
        b.data = {rand_bits(64), rand_bits(64)};
        b.keepdw = 4'b0011;
        drive_tx(b, 1'b0);
        b.data = {rand_bits(64), rand_bits(64)};
        b.keepdw = 4'b1111;
        drive_tx(b, 1'b0);
        b.data = {rand_bits(64), rand_bits(64)};
        b.keepdw = 4'b0111;
        drive_tx(b, 1'b0);
        finish_tx();
    endtask

    task automatic test_tx_backpressure();
        wide_beat_t b;
        int         n;
        b = '0;
        repeat (24) begin
            n = int'(rand_bits(2));
            b.data   = {rand_bits(64), rand_bits(64)};
            b.keepdw = 4'((1 << (n + 1)) - 1);
            b.last   = 1'(rand_bits(1));
            drive_tx(b, 1'b1);
        end
        finish_tx();
    endtask

    // ---------------------------------------
    // main sequence and watchdog
    // ---------------------------------------

    initial begin
        rst               = 1'b1;
        core_rx           = '0;
        core_rx_valid     = 1'b0;
        tx_in             = '0;
        tx_in_valid       = 1'b0;
        core_tx_ready     = 1'b0;
        cfg_interrupt_rdy = 1'b0;
        repeat (10) @(posedge clk_pcie);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_reset_state();
        test_interrupt();
        test_rx_packing();
        test_rx_tlps();
        test_tx_split();
        test_tx_backpressure();
        repeat (4) @(posedge clk_pcie);
        $display("value mismatches: %0d, protocol errors: %0d", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d clock periods", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- tlp_stream_bridge.f
hw/tlp_bridge_pkg.sv
hw/tlp_rx_widen.sv
hw/tlp_tx_narrow.sv
hw/irq_period_timer.sv
hw/tlp_stream_bridge.sv
tests/tb_tlp_stream_bridge.sv
